/* rtl/pc_hard_pkg.sv */
/*
 * Shared types and constants for the hardened PC front end:
 * address and instruction vectors, PC source encoding,
 * and the sequential PC increments
 */

package pc_hard_pkg;

  // Fetch PC and branch/jump/mret target
  typedef logic [31:0] addr_t;

  // Raw instruction word as returned by memory
  typedef logic [31:0] instr_t;

  // Source selected by the controller on a PC set
  // PC_BOOT never comes from the controller
  // The checker uses it as the idle value after reset
  typedef enum logic [1:0] {
    PC_JUMP   = 2'd0,
    PC_BRANCH = 2'd1,
    PC_MRET   = 2'd2,
    PC_BOOT   = 2'd3
  } pc_src_e;

  // Step for a compressed (16-bit) instruction
  localparam addr_t CMPR_INCR = 32'd2;

  // Step for a full-size (32-bit) instruction
  localparam addr_t FULL_INCR = 32'd4;

endpackage

/* rtl/pc_if.sv */
/*
 * PC update events from the PC generator to the redundant checker
 */

interface pc_if
  import pc_hard_pkg::*;
  ();

  addr_t   pc_if;      // Current fetch PC
  logic    adv;        // Sequential advance this cycle
  logic    incr_cmpr;  // Accepted word is compressed
  logic    set;        // Target load this cycle
  pc_src_e src;        // Source used for the load
  addr_t   tgt;        // Target used for the load
  logic    taken;      // Effective branch decision

  // Generator side
  modport gen (
    output pc_if, adv, incr_cmpr, set, src, tgt, taken
  );

  // Checker side, read only
  modport chk (
    input pc_if, adv, incr_cmpr, set, src, tgt, taken
  );

endinterface

/* rtl/pc_gen.sv */
/*
 * Fetch PC generator
 * PC register, next-PC selection between sequential step and target,
 * and the ready side of the instruction fetch handshake
 */

module pc_gen
  import pc_hard_pkg::*;
  #(
    parameter addr_t BOOT_ADDR = 32'h0000_0080
  ) (
    input  logic    clk_i,
    input  logic    rst_n_i,
    input  logic    instr_valid_i,
    input  instr_t  instr_rdata_i,
    input  logic    id_free_i,
    input  logic    pc_set_i,
    input  pc_src_e pc_src_i,
    input  addr_t   target_i,
    input  logic    branch_cmp_i,
    output logic    instr_ready_o,
    output addr_t   pc_o,
    output logic    fetch_o,
    pc_if.gen       pc_bus_o
  );

  addr_t pc_q;
  addr_t pc_d;
  addr_t incr;
  logic  fetch_en_q;
  logic  is_cmpr;
  logic  taken;

  // Fetch is held off for the first cycle out of reset
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      fetch_en_q <= 1'b0;
    end else begin
      fetch_en_q <= 1'b1;
    end
  end

  // Ready only when IF/ID can take a word and no set is pending
  assign instr_ready_o = fetch_en_q & id_free_i & ~pc_set_i;
  assign fetch_o       = instr_valid_i & instr_ready_o;

  // Low bits 2'b11 mark a full-size word
  assign is_cmpr = (instr_rdata_i[1:0] != 2'b11);
  assign incr    = is_cmpr ? CMPR_INCR : FULL_INCR;

  // Only branches depend on the compare result
  assign taken = (pc_src_i == PC_BRANCH) ? branch_cmp_i : 1'b1;

  // Next PC, a set wins over a fetch
  always_comb begin
    pc_d = pc_q;
    if (pc_set_i) begin
      if (taken) begin
        pc_d = target_i;
      end
    end else if (fetch_o) begin
      pc_d = pc_q + incr;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q <= BOOT_ADDR;
    end else begin
      pc_q <= pc_d;
    end
  end

  assign pc_o = pc_q;

  // Event report toward the checker
  assign pc_bus_o.pc_if     = pc_q;
  assign pc_bus_o.adv       = fetch_o;
  assign pc_bus_o.incr_cmpr = is_cmpr;
  assign pc_bus_o.set       = pc_set_i;
  assign pc_bus_o.src       = pc_src_i;
  assign pc_bus_o.tgt       = target_i;
  assign pc_bus_o.taken     = taken;

  // Boot address, targets and steps keep the PC halfword aligned
  a_pc_aligned : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    pc_q[0] == 1'b0
  );

endmodule

/* rtl/if_id_stage.sv */
/*
 * IF/ID pipeline register
 * One entry holding PC and instruction for decode,
 * compressed flag decode and valid/ready toward decode
 */

module if_id_stage
  import pc_hard_pkg::*;
  (
    input  logic   clk_i,
    input  logic   rst_n_i,
    input  logic   fetch_i,
    input  logic   flush_i,
    input  addr_t  pc_i,
    input  instr_t instr_i,
    input  logic   id_ready_i,
    output logic   free_o,
    output logic   id_valid_o,
    output addr_t  id_pc_o,
    output instr_t id_instr_o,
    output logic   id_compressed_o
  );

  logic   valid_q;
  addr_t  pc_q;
  instr_t instr_q;

  // Empty, or drained by decode in this same cycle
  assign free_o = ~valid_q | id_ready_i;

  // Flush drops the entry, fetch refills it, decode drains it
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (fetch_i) begin
      valid_q <= 1'b1;
    end else if (id_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  // Payload only moves on a fetch transfer
  always_ff @(posedge clk_i) begin
    if (fetch_i) begin
      pc_q    <= pc_i;
      instr_q <= instr_i;
    end
  end

  assign id_valid_o      = valid_q;
  assign id_pc_o         = pc_q;
  assign id_instr_o      = instr_q;
  assign id_compressed_o = (instr_q[1:0] != 2'b11);

  // Fetch must stall while decode back-pressures a held entry
  a_hold_stable : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    valid_q && !id_ready_i && !flush_i |=> valid_q && $stable(pc_q) && $stable(instr_q)
  );

endmodule

/* rtl/pc_check.sv */
/*
 * Redundant PC checker
 * Shadow PC recomputation, sequential step check against IF/ID,
 * hold check of target and decision after a set,
 * PC hardening setting and sticky major alert
 */

module pc_check
  import pc_hard_pkg::*;
  #(
    parameter addr_t BOOT_ADDR = 32'h0000_0080
  ) (
    input  logic    clk_i,
    input  logic    rst_n_i,
    input  logic    cfg_we_i,
    input  logic    cfg_pc_hardening_i,
    input  addr_t   id_pc_i,
    input  pc_src_e pc_src_i,
    input  addr_t   target_i,
    input  logic    branch_cmp_i,
    output logic    alert_major_o,
    pc_if.chk       pc_bus_i
  );

  logic    hardening_q;
  logic    alert_q;
  addr_t   shadow_q;
  logic    evt_q;
  logic    adv_q;
  logic    cmpr_q;
  logic    set_q;
  pc_src_e src_q;
  addr_t   tgt_q;
  logic    taken_q;
  logic    own_taken;
  addr_t   step;
  logic    pc_fault;
  logic    seq_fault;
  logic    hold_fault;

  // Decision recomputed from the controller inputs
  assign own_taken = (pc_src_i != PC_BRANCH) | branch_cmp_i;
  assign step      = pc_bus_i.incr_cmpr ? CMPR_INCR : FULL_INCR;

  // Setting defaults to on out of reset
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      hardening_q <= 1'b1;
    end else if (cfg_we_i) begin
      hardening_q <= cfg_pc_hardening_i;
    end
  end

  // Shadow PC follows the reported events with its own arithmetic
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      shadow_q <= BOOT_ADDR;
      evt_q    <= 1'b0;
      adv_q    <= 1'b0;
      cmpr_q   <= 1'b0;
    end else begin
      if (pc_bus_i.set) begin
        if (own_taken) begin
          shadow_q <= target_i;
        end
      end else if (pc_bus_i.adv) begin
        shadow_q <= shadow_q + step;
      end
      evt_q  <= pc_bus_i.set | pc_bus_i.adv;
      adv_q  <= pc_bus_i.adv & ~pc_bus_i.set;
      cmpr_q <= pc_bus_i.incr_cmpr;
    end
  end

  // Values the generator used at the set, checked in the hardened cycle
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      set_q   <= 1'b0;
      src_q   <= PC_BOOT;
      tgt_q   <= BOOT_ADDR;
      taken_q <= 1'b0;
    end else begin
      set_q <= pc_bus_i.set;
      if (pc_bus_i.set) begin
        src_q   <= pc_bus_i.src;
        tgt_q   <= pc_bus_i.tgt;
        taken_q <= pc_bus_i.taken;
      end
    end
  end

  // PC against the shadow after any event
  assign pc_fault = evt_q && (pc_bus_i.pc_if != shadow_q);

  // After an advance the fetched word sits in IF/ID
  assign seq_fault = adv_q &&
                     (pc_bus_i.pc_if != id_pc_i + (cmpr_q ? CMPR_INCR : FULL_INCR));

  // Source, target or decision moved during the hold cycle
  assign hold_fault = set_q &&
                      ((pc_src_i != src_q) || (target_i != tgt_q) || (own_taken != taken_q));

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      alert_q <= 1'b0;
    end else if (hardening_q && (pc_fault || seq_fault || hold_fault)) begin
      alert_q <= 1'b1;
    end
  end

  assign alert_major_o = alert_q;

  // Generator reports an advance or a set in a cycle, never both
  a_adv_set_excl : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !(pc_bus_i.adv && pc_bus_i.set)
  );

endmodule

/* rtl/pc_hard_top.sv */
/*
 * Hardened PC front end top level
 * PC generator, IF/ID register and redundant checker
 */

module pc_hard_top
  import pc_hard_pkg::*;
  #(
    parameter addr_t BOOT_ADDR = 32'h0000_0080
  ) (
    input  logic    clk_i,
    input  logic    rst_n_i,
    // Fetch
    input  logic    instr_valid_i,
    input  instr_t  instr_rdata_i,
    output logic    instr_ready_o,
    output addr_t   instr_addr_o,
    // Decode
    output logic    id_valid_o,
    output addr_t   id_pc_o,
    output instr_t  id_instr_o,
    output logic    id_compressed_o,
    input  logic    id_ready_i,
    // Controller
    input  logic    pc_set_i,
    input  pc_src_e pc_src_i,
    input  addr_t   target_i,
    input  logic    branch_cmp_i,
    // Configuration and alert
    input  logic    cfg_we_i,
    input  logic    cfg_pc_hardening_i,
    output logic    alert_major_o
  );

  logic id_free;
  logic fetch;

  pc_if pc_bus ();

  pc_gen #(
    .BOOT_ADDR (BOOT_ADDR)
  ) pc_gen_i (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .instr_valid_i (instr_valid_i),
    .instr_rdata_i (instr_rdata_i),
    .id_free_i     (id_free),
    .pc_set_i      (pc_set_i),
    .pc_src_i      (pc_src_i),
    .target_i      (target_i),
    .branch_cmp_i  (branch_cmp_i),
    .instr_ready_o (instr_ready_o),
    .pc_o          (instr_addr_o),
    .fetch_o       (fetch),
    .pc_bus_o      (pc_bus.gen)
  );

  // A set flushes whatever waits for decode
  if_id_stage if_id_stage_i (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .fetch_i         (fetch),
    .flush_i         (pc_set_i),
    .pc_i            (instr_addr_o),
    .instr_i         (instr_rdata_i),
    .id_ready_i      (id_ready_i),
    .free_o          (id_free),
    .id_valid_o      (id_valid_o),
    .id_pc_o         (id_pc_o),
    .id_instr_o      (id_instr_o),
    .id_compressed_o (id_compressed_o)
  );

  pc_check #(
    .BOOT_ADDR (BOOT_ADDR)
  ) pc_check_i (
    .clk_i              (clk_i),
    .rst_n_i            (rst_n_i),
    .cfg_we_i           (cfg_we_i),
    .cfg_pc_hardening_i (cfg_pc_hardening_i),
    .id_pc_i            (id_pc_o),
    .pc_src_i           (pc_src_i),
    .target_i           (target_i),
    .branch_cmp_i       (branch_cmp_i),
    .alert_major_o      (alert_major_o),
    .pc_bus_i           (pc_bus.chk)
  );

endmodule

/* tests/pc_hard_tb.sv */
/*
 * Testbench for the hardened PC front end
 * Clock, reset, fetch memory and controller models,
 * directed tests for reset, sequential flow, target loads and hold glitches
 */

module pc_hard_tb
  import pc_hard_pkg::*;
  ();

  localparam addr_t BOOT_ADDR = 32'h0000_0080;

  logic    clk_i;
  logic    rst_n_i;
  logic    instr_valid_i;
  instr_t  instr_rdata_i;
  logic    instr_ready_o;
  addr_t   instr_addr_o;
  logic    id_valid_o;
  addr_t   id_pc_o;
  instr_t  id_instr_o;
  logic    id_compressed_o;
  logic    id_ready_i;
  logic    pc_set_i;
  pc_src_e pc_src_i;
  addr_t   target_i;
  logic    branch_cmp_i;
  logic    cfg_we_i;
  logic    cfg_pc_hardening_i;
  logic    alert_major_o;

  // Memory contents, one word per halfword slot
  instr_t      rom [128];
  // Fetch PC expected from the advance and load rules
  addr_t       model_pc;
  logic [31:0] lfsr_q;

  pc_hard_top #(
    .BOOT_ADDR (BOOT_ADDR)
  ) dut_i (
    .clk_i              (clk_i),
    .rst_n_i            (rst_n_i),
    .instr_valid_i      (instr_valid_i),
    .instr_rdata_i      (instr_rdata_i),
    .instr_ready_o      (instr_ready_o),
    .instr_addr_o       (instr_addr_o),
    .id_valid_o         (id_valid_o),
    .id_pc_o            (id_pc_o),
    .id_instr_o         (id_instr_o),
    .id_compressed_o    (id_compressed_o),
    .id_ready_i         (id_ready_i),
    .pc_set_i           (pc_set_i),
    .pc_src_i           (pc_src_i),
    .target_i           (target_i),
    .branch_cmp_i       (branch_cmp_i),
    .cfg_we_i           (cfg_we_i),
    .cfg_pc_hardening_i (cfg_pc_hardening_i),
    .alert_major_o      (alert_major_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      abort_run($sformatf("[FAIL] %s is 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      val    = {val[30:0], fb};
    end
    return val;
  endfunction

  // Low bits 2'b11 mean a full-size word
  function automatic addr_t step_of(input instr_t w);
    return (w[1:0] == 2'b11) ? FULL_INCR : CMPR_INCR;
  endfunction

  function automatic instr_t word_at(input addr_t a);
    return rom[a[7:1]];
  endfunction

  task automatic apply_reset();
    @(posedge clk_i);
    rst_n_i    <= 1'b0;
    pc_set_i   <= 1'b0;
    cfg_we_i   <= 1'b0;
    id_ready_i <= 1'b0;
    repeat (8) @(posedge clk_i);
    rst_n_i <= 1'b1;
  endtask

  // Memory side of fetch
  // Drops valid after each transfer or set and offers the next word a cycle later
  task automatic serve_fetch();
    forever begin
      @(posedge clk_i);
      if (!rst_n_i) begin
        instr_valid_i <= 1'b0;
        model_pc      <= BOOT_ADDR;
      end else if (pc_set_i) begin
        instr_valid_i <= 1'b0;
        if (pc_src_i != PC_BRANCH || branch_cmp_i) begin
          model_pc <= target_i;
        end
      end else if (instr_valid_i && instr_ready_o) begin
        instr_valid_i <= 1'b0;
        model_pc      <= model_pc + step_of(instr_rdata_i);
      end else begin
        expect_eq("instr_addr_o", instr_addr_o, model_pc);
        instr_valid_i <= 1'b1;
        instr_rdata_i <= word_at(instr_addr_o);
      end
    end
  endtask

  // One-cycle set, returns on the edge that starts the hardened cycle
  task automatic set_pc(input pc_src_e src, input addr_t tgt, input logic cmp);
    @(posedge clk_i);
    pc_set_i     <= 1'b1;
    pc_src_i     <= src;
    target_i     <= tgt;
    branch_cmp_i <= cmp;
    @(posedge clk_i);
    pc_set_i <= 1'b0;
  endtask

  task automatic expect_alert_low(input int cycles);
    repeat (cycles) begin
      @(negedge clk_i);
      expect_eq("alert_major_o", alert_major_o, 1'b0);
    end
  endtask

  // Called on the edge that ends the hardened cycle
  task automatic expect_alert_sticky();
    repeat (10) begin
      @(negedge clk_i);
      expect_eq("alert_major_o", alert_major_o, 1'b1);
    end
  endtask

  task automatic check_reset_state();
    apply_reset();
    @(negedge clk_i);
    expect_eq("instr_addr_o", instr_addr_o, BOOT_ADDR);
    expect_eq("instr_ready_o", instr_ready_o, 1'b0);
    expect_eq("id_valid_o", id_valid_o, 1'b0);
    expect_eq("alert_major_o", alert_major_o, 1'b0);
  endtask

  // Decode stalls at random, each accepted PC follows the previous word's size
  task automatic run_sequential_flow(input int count);
    addr_t  exp_pc;
    instr_t word;
    int     seen;
    int     cycles;
    exp_pc = BOOT_ADDR;
    seen   = 0;
    cycles = 0;
    while (seen < count) begin
      @(posedge clk_i);
      id_ready_i <= (rand_bits(2) != 32'd0);
      @(negedge clk_i);
      cycles++;
      assert (cycles < 40 * count) else abort_run("sequential flow stopped making progress");
      expect_eq("alert_major_o", alert_major_o, 1'b0);
      if (id_valid_o && id_ready_i) begin
        word = word_at(exp_pc);
        expect_eq("id_pc_o", id_pc_o, exp_pc);
        expect_eq("id_instr_o", id_instr_o, word);
        expect_eq("id_compressed_o", id_compressed_o, word[1:0] != 2'b11);
        exp_pc = exp_pc + step_of(word);
        seen++;
      end
    end
  endtask

  task automatic load_and_follow(input pc_src_e src, input addr_t tgt, input logic cmp);
    addr_t exp_pc;
    int    cycles;
    set_pc(src, tgt, cmp);
    // Held through the hardened cycle, free to move after it
    @(posedge clk_i);
    target_i     <= 32'h0;
    branch_cmp_i <= ~cmp;
    @(negedge clk_i);
    exp_pc = (src == PC_BRANCH && !cmp) ? model_pc : tgt;
    cycles = 0;
    while (!(id_valid_o && id_ready_i)) begin
      cycles++;
      assert (cycles < 20) else abort_run("no decode transfer after the target load");
      @(negedge clk_i);
    end
    expect_eq("id_pc_o", id_pc_o, exp_pc);
    expect_eq("alert_major_o", alert_major_o, 1'b0);
  endtask

  task automatic load_legal_targets();
    @(posedge clk_i);
    id_ready_i <= 1'b1;
    load_and_follow(PC_JUMP, 32'h0000_0100, 1'b0);
    load_and_follow(PC_MRET, 32'h0000_00c6, 1'b0);
    load_and_follow(PC_BRANCH, 32'h0000_0142, 1'b1);
    // Not taken, falls through to the sequential PC
    load_and_follow(PC_BRANCH, 32'h0000_01f0, 1'b0);
  endtask

  task automatic glitch_target();
    set_pc(PC_JUMP, 32'h0000_0110, 1'b0);
    target_i <= 32'h0000_0114;
    // Fault only shows on the edge that ends the hardened cycle
    @(negedge clk_i);
    expect_eq("alert_major_o", alert_major_o, 1'b0);
    @(posedge clk_i);
  endtask

  task automatic glitch_decision();
    set_pc(PC_BRANCH, 32'h0000_0130, 1'b1);
    branch_cmp_i <= 1'b0;
    @(negedge clk_i);
    expect_eq("alert_major_o", alert_major_o, 1'b0);
    @(posedge clk_i);
  endtask

  task automatic glitched_target_alert();
    glitch_target();
    expect_alert_sticky();
    apply_reset();
    @(negedge clk_i);
    expect_eq("alert_major_o", alert_major_o, 1'b0);
  endtask

  task automatic glitched_decision_alert();
    glitch_decision();
    expect_alert_sticky();
    apply_reset();
    @(negedge clk_i);
    expect_eq("alert_major_o", alert_major_o, 1'b0);
  endtask

  task automatic hardening_off();
    @(posedge clk_i);
    cfg_we_i           <= 1'b1;
    cfg_pc_hardening_i <= 1'b0;
    @(posedge clk_i);
    cfg_we_i <= 1'b0;
    glitch_target();
    expect_alert_low(20);
    glitch_decision();
    expect_alert_low(20);
  endtask

  initial begin
    rst_n_i            = 1'b0;
    instr_valid_i      = 1'b0;
    instr_rdata_i      = '0;
    id_ready_i         = 1'b0;
    pc_set_i           = 1'b0;
    pc_src_i           = PC_JUMP;
    target_i           = '0;
    branch_cmp_i       = 1'b0;
    cfg_we_i           = 1'b0;
    cfg_pc_hardening_i = 1'b1;
    model_pc           = BOOT_ADDR;
    lfsr_q             = 32'd77227;
    // Random mix of compressed and full-size words
    for (int i = 0; i < 128; i++) begin
      rom[i] = rand_bits(32);
    end
    fork
      serve_fetch();
    join_none
    check_reset_state();
    run_sequential_flow(24);
    load_legal_targets();
    glitched_target_alert();
    glitched_decision_alert();
    hardening_off();
    $display("all tests passed");
    $finish;
  end

endmodule

/* pc_hard_top.f */
rtl/pc_hard_pkg.sv
rtl/pc_if.sv
rtl/pc_gen.sv
rtl/if_id_stage.sv
rtl/pc_check.sv
rtl/pc_hard_top.sv
tests/pc_hard_tb.sv

/* Bender.yml */
package:
  name: pc_hard

sources:
  - rtl/pc_hard_pkg.sv
  - rtl/pc_if.sv
  - rtl/pc_gen.sv
  - rtl/if_id_stage.sv
  - rtl/pc_check.sv
  - rtl/pc_hard_top.sv
  - target: test
    files:
      - tests/pc_hard_tb.sv
